//--- dv/fetch_vectors.txt
# m addr inst : memory image word, missing words read as nop
# t name cmd arg1 arg2 arg3 count expected_addrs : redirect addr, stall addr cycles, update pc target taken
m 00000000 00100093
m 00000004 00200113
m 00000008 00300193
m 0000000c 00400213
m 00000010 0200006f
m 00000014 00500293
m 00000018 00600313
m 00000030 00700393
m 00000034 00800413
m 00000038 00900493
m 00000080 00a00513
m 000000a0 00b00593
t reset_seq run 0 0 0 4 00000000 00000004 00000008 0000000c
t jal_jump run 0 0 0 4 00000010 00000030 00000034 00000038
t redirect_flush redirect 80 0 0 3 00000080 00000084 00000088
t stall_decode stall a0 32 0 9 a0 a4 a8 ac b0 b4 b8 bc c0
t bp_taken update 40 60 1 3 00000040 00000060 00000064
t bp_not_taken_1 update 40 60 0 3 00000040 00000044 00000048
t bp_not_taken_2 update 40 60 0 3 00000040 00000044 00000048

//--- dv/tb_fetch.sv
`default_nettype none

module tb_fetch
    import fetch_pkg::*;
();

    localparam int QUEUE_DEPTH = 8;
    localparam int BHT_ENTRIES = 16;
    localparam inst_t NOP_WORD = 32'h0000_0013;

    logic clk;
    logic rst_n;
    logic mem_req_valid;
    addr_t mem_req_addr;
    logic mem_req_ready;
    logic mem_resp_valid;
    addr_t mem_resp_addr;
    inst_t mem_resp_inst;
    logic redirect_valid;
    addr_t redirect_addr;
    logic upd_valid;
    addr_t upd_pc;
    logic upd_taken;
    addr_t upd_target;
    logic deq_valid;
    addr_t deq_addr;
    inst_t deq_inst;
    logic deq_ready;

    // memory image and the expected taken/not-taken state per branch pc
    inst_t image [addr_t];
    logic [1:0] bp_cnt [addr_t];
    addr_t bp_tgt [addr_t];

    // test table read from the vector file
    string t_name [$];
    string t_cmd [$];
    addr_t t_arg1 [$];
    addr_t t_arg2 [$];
    addr_t t_arg3 [$];
    int t_first [$];
    int t_count [$];
    addr_t exp_addr [$];

    // reads in flight inside the memory model, oldest first
    addr_t p_addr [$];
    int p_due [$];
    addr_t got_addr [$];
    inst_t got_inst [$];

    logic [31:0] lcg_state;
    logic [31:0] lat_r;
    int due_c;
    int cyc;
    int limit;
    int want;
    int req_count;
    int stall_reads;
    int errors;
    int passed;
    int failed;
    logic have_prev;
    addr_t last_addr;

    fetch_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .BHT_ENTRIES (BHT_ENTRIES)
    ) uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_addr  (mem_resp_addr),
        .mem_resp_inst  (mem_resp_inst),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr),
        .upd_valid      (upd_valid),
        .upd_pc         (upd_pc),
        .upd_taken      (upd_taken),
        .upd_target     (upd_target),
        .deq_valid      (deq_valid),
        .deq_addr       (deq_addr),
        .deq_inst       (deq_inst),
        .deq_ready      (deq_ready)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic inst_t image_word(addr_t a);
        if (image.exists(a)) begin
            return image[a];
        end
        return NOP_WORD;
    endfunction

    // jal first, then a taken prediction, else the next word
    function automatic addr_t model_next(addr_t a);
        inst_t w;
        addr_t imm;
        w = image_word(a);
        if (w[6:0] == OPCODE_JAL) begin
            imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            return a + imm;
        end
        if (bp_cnt.exists(a) && bp_cnt[a] >= 2'd2) begin
            return bp_tgt[a];
        end
        return a + 32'd4;
    endfunction

    // one clock, inputs change 1 unit after the edge
    task automatic step();
        logic [31:0] r;
        @(posedge clk);
        #1;
        cyc = cyc + 1;
        r = lcg_next();
        mem_req_ready = (r[17:16] != 2'b00);
        deq_ready = (got_addr.size() < want) && r[20];
        redirect_valid = 1'b0;
        upd_valid = 1'b0;
        mem_resp_valid = 1'b0;
        if (p_due.size() > 0 && p_due[0] <= cyc) begin
            mem_resp_valid = 1'b1;
            mem_resp_addr = p_addr.pop_front();
            mem_resp_inst = image_word(mem_resp_addr);
            void'(p_due.pop_front());
        end
    endtask

    task automatic redirect_to(addr_t a);
        step();
        redirect_valid = 1'b1;
        redirect_addr = a;
        have_prev = 1'b0;
        req_count = 0;
        step();
    endtask

    task automatic collect(int ti);
        addr_t act;
        inst_t ins;
        addr_t exp;
        logic bad;
        bad = 1'b0;
        want = t_count[ti];
        while (got_addr.size() < t_count[ti]) begin
            step();
        end
        want = 0;
        for (int i = 0; i < t_count[ti]; i++) begin
            act = got_addr.pop_front();
            ins = got_inst.pop_front();
            exp = exp_addr[t_first[ti] + i];
            if (act != exp) begin
                $display("[ERROR] %s: address expected %h actual %h", t_name[ti], exp, act);
                bad = 1'b1;
            end
            if (ins != image_word(act)) begin
                $display("[ERROR] %s: instruction expected %h actual %h",
                    t_name[ti], image_word(act), ins);
                bad = 1'b1;
            end
            if (have_prev && act != model_next(last_addr)) begin
                $display("[ERROR] %s: model address expected %h actual %h",
                    t_name[ti], model_next(last_addr), act);
                bad = 1'b1;
            end
            have_prev = 1'b1;
            last_addr = act;
        end
        if (t_cmd[ti] == "stall" && stall_reads > QUEUE_DEPTH) begin
            $display("%s: %0d reads accepted while decode was stalled, at most %0d allowed",
                t_name[ti], stall_reads, QUEUE_DEPTH);
            bad = 1'b1;
        end
        if (bad) begin
            errors = errors + 1;
            failed = failed + 1;
            $display("%s: failed", t_name[ti]);
        end else begin
            passed = passed + 1;
            $display("%s: passed", t_name[ti]);
        end
    endtask

    task automatic load_vectors(output logic ok);
        int fd;
        int n;
        int cnt;
        int total;
        string line;
        string kind;
        string nm;
        string cm;
        addr_t a1;
        addr_t a2;
        addr_t a3;
        addr_t ev [9];
        total = 0;
        fd = $fopen("dv/fetch_vectors.txt", "r");
        ok = (fd != 0);
        while (ok && !$feof(fd)) begin
            line = "";
            kind = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%s", kind);
            if (kind == "m") begin
                n = $sscanf(line, "%s %h %h", kind, a1, a2);
                image[a1] = a2;
            end else if (kind == "t") begin
                n = $sscanf(line, "%s %s %s %h %h %h %d %h %h %h %h %h %h %h %h %h",
                    kind, nm, cm, a1, a2, a3, cnt, ev[0], ev[1], ev[2], ev[3],
                    ev[4], ev[5], ev[6], ev[7], ev[8]);
                t_name.push_back(nm);
                t_cmd.push_back(cm);
                t_arg1.push_back(a1);
                t_arg2.push_back(a2);
                t_arg3.push_back(a3);
                t_first.push_back(exp_addr.size());
                t_count.push_back(cnt);
                for (int i = 0; i < cnt; i++) begin
                    exp_addr.push_back(ev[i]);
                end
                total = total + cnt;
            end
        end
        limit = 40 * total;
    endtask

    // reads and dequeues are sampled mid-cycle, ahead of the edge they complete on
    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_req_valid && mem_req_ready) begin
                lat_r = lcg_next();
                due_c = cyc + 2 + int'(lat_r[17:16] % 2'd3);
                if (p_due.size() > 0 && due_c <= p_due[$]) begin
                    due_c = p_due[$] + 1;
                end
                p_addr.push_back(mem_req_addr);
                p_due.push_back(due_c);
                req_count = req_count + 1;
            end
            if (deq_valid && deq_ready) begin
                got_addr.push_back(deq_addr);
                got_inst.push_back(deq_inst);
            end
        end
    end

    always @(posedge clk) begin
        if (limit > 0 && cyc > limit) begin
            $display("timeout after %0d cycles, decode output stopped", cyc);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        logic ok;
        clk = 1'b0;
        rst_n = 1'b0;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_addr = '0;
        mem_resp_inst = '0;
        redirect_valid = 1'b0;
        redirect_addr = '0;
        upd_valid = 1'b0;
        upd_pc = '0;
        upd_taken = 1'b0;
        upd_target = '0;
        deq_ready = 1'b0;
        lcg_state = 32'd20152;
        cyc = 0;
        limit = 0;
        want = 0;
        req_count = 0;
        stall_reads = 0;
        errors = 0;
        passed = 0;
        failed = 0;
        have_prev = 1'b0;
        last_addr = '0;
        load_vectors(ok);
        repeat (4) step();
        rst_n = 1'b1;
        if (!ok) begin
            $display("could not open the vector file");
            errors = 1;
        end
        for (int t = 0; ok && t < t_name.size(); t++) begin
            if (t_cmd[t] == "redirect") begin
                redirect_to(t_arg1[t]);
            end else if (t_cmd[t] == "stall") begin
                redirect_to(t_arg1[t]);
                repeat (int'(t_arg2[t])) step();
                stall_reads = req_count;
            end else if (t_cmd[t] == "update") begin
                step();
                upd_valid = 1'b1;
                upd_pc = t_arg1[t];
                upd_target = t_arg2[t];
                upd_taken = t_arg3[t][0];
                if (!bp_cnt.exists(t_arg1[t])) begin
                    bp_cnt[t_arg1[t]] = 2'd1;
                end
                if (t_arg3[t][0] && bp_cnt[t_arg1[t]] != 2'd3) begin
                    bp_cnt[t_arg1[t]] = bp_cnt[t_arg1[t]] + 2'd1;
                end else if (!t_arg3[t][0] && bp_cnt[t_arg1[t]] != 2'd0) begin
                    bp_cnt[t_arg1[t]] = bp_cnt[t_arg1[t]] - 2'd1;
                end
                if (t_arg3[t][0]) begin
                    bp_tgt[t_arg1[t]] = t_arg2[t];
                end
                redirect_to(t_arg1[t]);
            end
            collect(t);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
            t_name.size(), passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hdl/fetch_pkg.sv
hdl/predict_pkg.sv
hdl/imem_port.sv
hdl/fetch_pc_gen.sv
hdl/branch_predictor.sv
hdl/inst_queue.sv
hdl/fetch_top.sv
dv/tb_fetch.sv

//--- hdl/branch_predictor.sv
`default_nettype none

module branch_predictor
    import fetch_pkg::*;
    import predict_pkg::*;
#(
    parameter int BHT_ENTRIES = 16
) (
    input wire clk,
    input wire rst_n,

    input wire addr_t cur_pc,

    input wire upd_valid,
    input wire addr_t upd_pc,
    input wire upd_taken,
    input wire addr_t upd_target,

    output addr_t pred_next
);

    localparam int IDX_W = $clog2(BHT_ENTRIES);

    logic [BHT_ENTRIES-1:0] ent_valid;
    counter_t ent_cnt [BHT_ENTRIES];
    bht_tag_t ent_tag [BHT_ENTRIES];
    addr_t ent_target [BHT_ENTRIES];

    bht_idx_t cur_idx;
    bht_idx_t upd_idx;
    bht_tag_t cur_tag;
    bht_tag_t upd_tag;
    logic cur_hit;
    counter_t upd_cnt;

    // index from the bits above bit 1, tag from what is left
    assign cur_idx = bht_idx_t'(cur_pc[IDX_W+1:2]);
    assign upd_idx = bht_idx_t'(upd_pc[IDX_W+1:2]);
    assign cur_tag = bht_tag_t'(cur_pc[31:2] >> IDX_W);
    assign upd_tag = bht_tag_t'(upd_pc[31:2] >> IDX_W);

    assign cur_hit = ent_valid[cur_idx[IDX_W-1:0]]
        && (ent_tag[cur_idx[IDX_W-1:0]] == cur_tag)
        && (ent_cnt[cur_idx[IDX_W-1:0]] >= CNT_WEAK_T);

    assign pred_next = cur_hit ? ent_target[cur_idx[IDX_W-1:0]] : cur_pc + INST_BYTES;

    // saturating step toward the reported outcome
    always_comb begin
        upd_cnt = ent_cnt[upd_idx[IDX_W-1:0]];
        if (upd_taken) begin
            if (upd_cnt != CNT_STRONG_T) begin
                upd_cnt = upd_cnt + 2'd1;
            end
        end else begin
            if (upd_cnt != CNT_STRONG_NT) begin
                upd_cnt = upd_cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= '0;
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                ent_cnt[i] <= CNT_WEAK_NT;
            end
        end else if (upd_valid) begin
            ent_valid[upd_idx[IDX_W-1:0]] <= 1'b1;
            ent_cnt[upd_idx[IDX_W-1:0]] <= upd_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid) begin
            ent_tag[upd_idx[IDX_W-1:0]] <= upd_tag;
            // not-taken updates keep the old target
            if (upd_taken) begin
                ent_target[upd_idx[IDX_W-1:0]] <= upd_target;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_pc_gen.sv
`default_nettype none

module fetch_pc_gen
    import fetch_pkg::*;
(
    input wire clk,
    input wire rst_n,

    input wire redirect_valid,
    input wire addr_t redirect_addr,

    input wire fetch_fire,
    input wire resp_hit,
    input wire addr_t resp_addr,
    input wire inst_t resp_inst,

    input wire addr_t pred_next,

    output addr_t fetch_pc,
    output logic kill,
    output logic flush
);

    addr_t pc_q;

    // last instruction written to the queue
    addr_t last_pc_q;
    inst_t last_inst_q;

    // read sent to memory and not yet answered
    logic pend_q;
    addr_t pend_addr_q;

    opcode_t last_op;
    addr_t jal_imm;
    addr_t jal_target;
    logic last_is_jal;
    logic jal_hazard;
    addr_t next_pc;

    // J-type immediate, sign extended, bit 0 always zero
    assign jal_imm = {
        {11{last_inst_q[31]}},
        last_inst_q[31],
        last_inst_q[19:12],
        last_inst_q[20],
        last_inst_q[30:21],
        1'b0
    };

    assign last_op = last_inst_q[6:0];
    assign last_is_jal = (last_op == OPCODE_JAL);
    assign jal_target = last_pc_q + jal_imm;

    // read in flight went down the wrong path after a jal
    assign jal_hazard = last_is_jal && pend_q && (pend_addr_q != jal_target);

    assign kill = redirect_valid || jal_hazard;
    assign flush = redirect_valid;
    assign fetch_pc = pc_q;

    // jal target is already being fetched, so continue behind it
    assign next_pc = last_is_jal ? jal_target + INST_BYTES : pred_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
            last_pc_q <= INVALID_WORD;
            last_inst_q <= INVALID_WORD;
            pend_q <= 1'b0;
        end else if (redirect_valid) begin
            pc_q <= redirect_addr;
            last_pc_q <= INVALID_WORD;
            last_inst_q <= INVALID_WORD;
            pend_q <= 1'b0;
        end else if (jal_hazard) begin
            // refetch from the jump target
            pc_q <= jal_target;
            last_pc_q <= INVALID_WORD;
            last_inst_q <= INVALID_WORD;
            pend_q <= 1'b0;
        end else begin
            if (fetch_fire) begin
                pc_q <= next_pc;
                pend_q <= 1'b1;
            end
            if (resp_hit) begin
                last_pc_q <= resp_addr;
                last_inst_q <= resp_inst;
                pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            pend_addr_q <= pc_q;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // widths of the fetch datapath
    localparam int ADDR_W = 32;
    localparam int INST_W = 32;
    localparam int OPCODE_W = 7;

    // byte address of an instruction
    typedef logic [ADDR_W-1:0] addr_t;

    // one RV32 instruction word
    typedef logic [INST_W-1:0] inst_t;

    // major opcode field, bits 6:0 of the word
    typedef logic [OPCODE_W-1:0] opcode_t;

    // jal rd, imm
    localparam opcode_t OPCODE_JAL = 7'b1101111;

    // first fetch address out of reset
    localparam addr_t RESET_PC = 32'h0000_0000;

    // size of one instruction in bytes
    localparam addr_t INST_BYTES = 32'd4;

    // marks the last-fetched registers as empty
    // (all ones is never a legal JAL, opcode field reads 7'h7f)
    localparam inst_t INVALID_WORD = 32'hffff_ffff;

endpackage

`default_nettype wire

//--- hdl/fetch_top.sv
`default_nettype none

module fetch_top
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8,
    parameter int BHT_ENTRIES = 16
) (
    input wire clk,
    input wire rst_n,

    output logic mem_req_valid,
    output addr_t mem_req_addr,
    input wire mem_req_ready,

    input wire mem_resp_valid,
    input wire addr_t mem_resp_addr,
    input wire inst_t mem_resp_inst,

    input wire redirect_valid,
    input wire addr_t redirect_addr,

    input wire upd_valid,
    input wire addr_t upd_pc,
    input wire upd_taken,
    input wire addr_t upd_target,

    output logic deq_valid,
    output addr_t deq_addr,
    output inst_t deq_inst,
    input wire deq_ready
);

    addr_t fetch_pc;
    addr_t pred_next;
    addr_t resp_addr;
    inst_t resp_inst;
    logic space_next;
    logic kill;
    logic flush;
    logic fetch_fire;
    logic resp_hit;

    imem_port u_port (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_addr     (fetch_pc),
        .space_next     (space_next),
        .kill           (kill),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_addr  (mem_resp_addr),
        .mem_resp_inst  (mem_resp_inst),
        .fetch_fire     (fetch_fire),
        .resp_hit       (resp_hit),
        .resp_addr      (resp_addr),
        .resp_inst      (resp_inst)
    );

    fetch_pc_gen u_pc_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr),
        .fetch_fire     (fetch_fire),
        .resp_hit       (resp_hit),
        .resp_addr      (resp_addr),
        .resp_inst      (resp_inst),
        .pred_next      (pred_next),
        .fetch_pc       (fetch_pc),
        .kill           (kill),
        .flush          (flush)
    );

    branch_predictor #(
        .BHT_ENTRIES (BHT_ENTRIES)
    ) u_bp (
        .clk        (clk),
        .rst_n      (rst_n),
        .cur_pc     (fetch_pc),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .upd_target (upd_target),
        .pred_next  (pred_next)
    );

    // matched responses go straight into the queue
    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .enq_valid  (resp_hit),
        .enq_addr   (resp_addr),
        .enq_inst   (resp_inst),
        .space_next (space_next),
        .deq_ready  (deq_ready),
        .deq_valid  (deq_valid),
        .deq_addr   (deq_addr),
        .deq_inst   (deq_inst)
    );

endmodule

`default_nettype wire

//--- hdl/imem_port.sv
`default_nettype none

module imem_port
    import fetch_pkg::*;
(
    input wire clk,
    input wire rst_n,

    input wire addr_t fetch_addr,
    input wire space_next,
    input wire kill,

    output logic mem_req_valid,
    output addr_t mem_req_addr,
    input wire mem_req_ready,

    input wire mem_resp_valid,
    input wire addr_t mem_resp_addr,
    input wire inst_t mem_resp_inst,

    output logic fetch_fire,
    output logic resp_hit,
    output addr_t resp_addr,
    output inst_t resp_inst
);

    // high from the second cycle after reset on
    logic run_q;

    // one read in flight and its address
    logic busy_q;
    addr_t busy_addr_q;

    assign mem_req_valid = run_q && !busy_q && space_next && !kill;
    assign mem_req_addr = fetch_addr;
    assign fetch_fire = mem_req_valid && mem_req_ready;

    // stale responses carry another address and fall out here
    assign resp_hit = busy_q && mem_resp_valid && (mem_resp_addr == busy_addr_q) && !kill;
    assign resp_addr = busy_addr_q;
    assign resp_inst = mem_resp_inst;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (kill || resp_hit) begin
                busy_q <= 1'b0;
            end else if (fetch_fire) begin
                busy_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            busy_addr_q <= fetch_addr;
        end
    end

    // a waiting request keeps its address until the memory takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> !mem_req_valid || $stable(mem_req_addr))
        else $error("request address changed while waiting for the memory");

endmodule

`default_nettype wire

//--- hdl/inst_queue.sv
`default_nettype none

module inst_queue
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8
) (
    input wire clk,
    input wire rst_n,

    input wire flush,

    input wire enq_valid,
    input wire addr_t enq_addr,
    input wire inst_t enq_inst,
    output logic space_next,

    input wire deq_ready,
    output logic deq_valid,
    output addr_t deq_addr,
    output inst_t deq_inst
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0] count_t;

    addr_t addr_mem [QUEUE_DEPTH];
    inst_t inst_mem [QUEUE_DEPTH];

    ptr_t wr_ptr_q;
    ptr_t rd_ptr_q;
    count_t count_q;
    count_t count_next;
    logic deq_fire;

    assign deq_valid = (count_q != '0);
    assign deq_fire = deq_valid && deq_ready;
    assign deq_addr = addr_mem[rd_ptr_q];
    assign deq_inst = inst_mem[rd_ptr_q];

    // occupancy once this cycle's enqueue and dequeue are done
    always_comb begin
        count_next = count_q;
        if (enq_valid) begin
            count_next = count_next + count_t'(1);
        end
        if (deq_fire) begin
            count_next = count_next - count_t'(1);
        end
    end

    // one free slot left for the read that may go out now
    assign space_next = flush || (count_next < count_t'(QUEUE_DEPTH));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else if (flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (enq_valid) begin
                wr_ptr_q <= wr_ptr_q + ptr_t'(1);
            end
            if (deq_fire) begin
                rd_ptr_q <= rd_ptr_q + ptr_t'(1);
            end
            count_q <= count_next;
        end
    end

    always_ff @(posedge clk) begin
        if (enq_valid && !flush) begin
            addr_mem[wr_ptr_q] <= enq_addr;
            inst_mem[wr_ptr_q] <= enq_inst;
        end
    end

    // the memory port only asks when a slot is guaranteed
    assert property (@(posedge clk) disable iff (!rst_n)
        enq_valid |-> (count_q < count_t'(QUEUE_DEPTH)) || deq_fire)
        else $error("instruction queue overflow");

    // read side never runs past the write side
    assert property (@(posedge clk) disable iff (!rst_n)
        (wr_ptr_q - rd_ptr_q) == ptr_t'(count_q))
        else $error("queue pointers disagree with the entry count");

endmodule

`default_nettype wire

//--- hdl/predict_pkg.sv
`default_nettype none

package predict_pkg;

    // index type is wide enough for up to 256 entries
    localparam int BHT_IDX_W = 8;

    // tag holds the word address with the index bits shifted out
    localparam int BHT_TAG_W = 30;

    // two-bit saturating counter
    typedef logic [1:0] counter_t;

    typedef logic [BHT_IDX_W-1:0] bht_idx_t;
    typedef logic [BHT_TAG_W-1:0] bht_tag_t;

    // counter encodings, taken from 2 upwards
    localparam counter_t CNT_STRONG_NT = 2'd0;
    localparam counter_t CNT_WEAK_NT = 2'd1;
    localparam counter_t CNT_WEAK_T = 2'd2;
    localparam counter_t CNT_STRONG_T = 2'd3;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the fetch testbench with Verilator, run from the project root
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_fetch -o tb_fetch \
    > build.log 2>&1 \
    && ./obj_dir/tb_fetch > sim.log 2>&1
cat sim.log 2>/dev/null || cat build.log
grep -q "^STATUS: PASS$" sim.log 2>/dev/null && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
